// File: Makefile
TOP := rasterTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f vlog.f

obj_dir/simv: vlog.f *.sv
	verilator --binary -Wno-fatal --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f vlog.f -o simv

sim: obj_dir/simv
	-./obj_dir/simv +verilator+error+limit+1000 > sim.log 2>&1
	@cat sim.log
	@grep -qx "TEST OK" sim.log || (echo "Simulation failed, see sim.log" && exit 1)

clean:
	rm -rf obj_dir sim.log

// File: edgeDivider.sv
module edgeDivider import rastPkg::*; (
	input  logic clk,
	input  logic arstN,
	input  logic divStart,
	input  logic signed [deltaW-1:0] divDx,
	input  logic [coordW-1:0] divDy,
	output logic divDone,
	output logic signed [deltaW-1:0] divQuot,
	output logic [coordW-1:0] divRem
);

	logic run;
	logic [divCntW-1:0] cnt;
	logic [deltaW-1:0] num;
	logic [coordW-1:0] part;
	logic negR;
	logic [coordW-1:0] dyR;
	logic [coordW:0] trial;
	logic [coordW:0] diff;
	logic fits;
	logic [coordW-1:0] partNext;
	logic [deltaW-1:0] numNext;

	// One restoring step per cycle.
	assign trial = {part, num[deltaW-1]};
	assign diff = trial - {1'b0, dyR};
	assign fits = trial >= {1'b0, dyR};
	assign partNext = fits ? diff[coordW-1:0] : trial[coordW-1:0];
	assign numNext = {num[deltaW-2:0], fits};

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			run <= 1'b0;
			cnt <= '0;
			divDone <= 1'b0;
		end else begin
			divDone <= 1'b0;
			if (divStart) begin
				run <= 1'b1;
				cnt <= divCntW'(divCycles);
			end else if (run) begin
				cnt <= cnt - 1'b1;
				if (cnt == divCntW'(1)) begin
					run <= 1'b0;
					divDone <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (divStart) begin
			num <= divDx[deltaW-1] ? -divDx : divDx;
			part <= '0;
			negR <= divDx[deltaW-1];
			dyR <= divDy;
		end else if (run) begin
			num <= numNext;
			part <= partNext;
			if (cnt == divCntW'(1)) begin
				// Floor correction for negative dx.
				if (negR && partNext != '0) begin
					divQuot <= ~numNext;
					divRem <= dyR - partNext;
				end else if (negR) begin
					divQuot <= ~numNext + 1'b1;
					divRem <= '0;
				end else begin
					divQuot <= numNext;
					divRem <= partNext;
				end
			end
		end
	end

endmodule

// File: edgeSorter.sv
module edgeSorter import rastPkg::*; (
	input  logic [vertN-1:0][coordW-1:0] vertX,
	input  logic [vertN-1:0][coordW-1:0] vertY,
	output logic [vertN-1:0][coordW-1:0] aX,
	output logic [vertN-1:0][coordW-1:0] aY,
	output logic [vertN-1:0][coordW-1:0] bX,
	output logic [vertN-1:0][coordW-1:0] bY
);

	logic [1:0] top;
	logic [1:0] mid;
	logic [1:0] bot;

	// First matching ordering wins on ties.
	always_comb begin
		if (vertY[0] >= vertY[1] && vertY[1] >= vertY[2]) begin
			top = 2'd2;
			mid = 2'd1;
			bot = 2'd0;
		end else if (vertY[1] >= vertY[2] && vertY[2] >= vertY[0]) begin
			top = 2'd0;
			mid = 2'd2;
			bot = 2'd1;
		end else if (vertY[2] >= vertY[0] && vertY[0] >= vertY[1]) begin
			top = 2'd1;
			mid = 2'd0;
			bot = 2'd2;
		end else if (vertY[0] >= vertY[2] && vertY[2] >= vertY[1]) begin
			top = 2'd1;
			mid = 2'd2;
			bot = 2'd0;
		end else if (vertY[2] >= vertY[1] && vertY[1] >= vertY[0]) begin
			top = 2'd0;
			mid = 2'd1;
			bot = 2'd2;
		end else begin
			// Only Y1 >= Y0 >= Y2 is left.
			top = 2'd2;
			mid = 2'd0;
			bot = 2'd1;
		end
	end

	always_comb begin
		// Long edge.
		aX[0] = vertX[top];
		aY[0] = vertY[top];
		bX[0] = vertX[bot];
		bY[0] = vertY[bot];

		// Upper short edge, ends at the middle vertex.
		aX[1] = vertX[top];
		aY[1] = vertY[top];
		bX[1] = vertX[mid];
		bY[1] = vertY[mid];

		// Lower short edge.
		aX[2] = vertX[mid];
		aY[2] = vertY[mid];
		bX[2] = vertX[bot];
		bY[2] = vertY[bot];
	end

endmodule

// File: edgeWalker.sv
module edgeWalker import rastPkg::*; (
	input  logic clk,
	input  logic arstN,
	input  logic load,
	input  logic step,
	input  logic [coordW-1:0] startX,
	input  logic signed [deltaW-1:0] quot,
	input  logic [coordW-1:0] rem,
	input  logic [coordW-1:0] dy,
	output logic [coordW-1:0] curX
);

	logic signed [deltaW-1:0] quotR;
	logic [coordW-1:0] remR;
	logic [coordW-1:0] dyR;
	logic [coordW-1:0] err;
	logic [coordW:0] errSum;
	logic [coordW:0] errNext;
	logic carry;
	logic [deltaW-1:0] xNext;

	assign errSum = {1'b0, err} + {1'b0, remR};
	assign carry = errSum >= {1'b0, dyR};
	assign errNext = carry ? errSum - {1'b0, dyR} : errSum;

	// Extra unit when the error wraps past dy.
	assign xNext = {1'b0, curX} + quotR + {{(deltaW-1){1'b0}}, carry};

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			curX <= '0;
			err <= '0;
		end else if (load) begin
			curX <= startX;
			err <= '0;
		end else if (step) begin
			curX <= xNext[coordW-1:0];
			err <= errNext[coordW-1:0];
		end
	end

	// Edge slope is latched off the shared load bus.
	always_ff @(posedge clk) begin
		if (load) begin
			quotR <= quot;
			remR <= rem;
			dyR <= dy;
		end
	end

endmodule

// File: rastPkg.sv
package rastPkg;

	// Vertex coordinates.
	localparam int coordW = 12;
	localparam int vertN = 3;

	// Signed edge dx, one bit wider than a coordinate.
	localparam int deltaW = coordW + 1;

	// Serial divider, one iteration per quotient bit.
	localparam int divCycles = deltaW;
	localparam int divCntW = $clog2(divCycles + 1);

	// Span control FSM states.
	localparam int stW = 3;
	localparam logic [stW-1:0] stIdle = 3'd0;
	localparam logic [stW-1:0] stSetup = 3'd1;
	localparam logic [stW-1:0] stDiv = 3'd2;
	localparam logic [stW-1:0] stWalk = 3'd3;
	localparam logic [stW-1:0] stFinish = 3'd4;

endpackage

// File: rasterChecker.sv
module rasterChecker import rastPkg::*; (
	input logic clk,
	input logic arstN,
	input logic newTri,
	input logic [vertN-1:0][coordW-1:0] triX,
	input logic [vertN-1:0][coordW-1:0] triY,
	input int triSpans,
	input logic spansKnown,
	input logic spanValid,
	input logic [coordW-1:0] spanY,
	input logic [coordW-1:0] spanXl,
	input logic [coordW-1:0] spanXr,
	input logic done,
	output int valueErrs,
	output int protoErrs
);

	timeunit 1ns;
	timeprecision 100ps;

	int expY[$];
	int expL[$];
	int expR[$];
	int seen;
	int wantSpans;
	bit wantKnown;
	bit active;
	bit prevValid;

	initial begin
		valueErrs = 0;
		protoErrs = 0;
		active = 1'b0;
		prevValid = 1'b0;
	end

	// Floor division, so negative slopes round down.
	function automatic int edgeX(input int xa, input int ya, input int xb, input int yb,
		input int y);
		int num;
		int den;
		int q;
		num = (y - ya) * (xb - xa);
		den = yb - ya;
		q = num / den;
		if (num % den != 0 && num < 0)
			q = q - 1;
		return xa + q;
	endfunction

	task automatic buildSpans(input logic [vertN-1:0][coordW-1:0] vx,
		input logic [vertN-1:0][coordW-1:0] vy);
		int x[vertN];
		int y[vertN];
		int t;
		int lx;
		int sx;
		for (int i = 0; i < vertN; i++) begin
			x[i] = vx[i];
			y[i] = vy[i];
		end
		for (int i = 0; i < vertN - 1; i++) begin
			for (int j = 0; j < vertN - 1 - i; j++) begin
				if (y[j] > y[j+1]) begin
					t = y[j];
					y[j] = y[j+1];
					y[j+1] = t;
					t = x[j];
					x[j] = x[j+1];
					x[j+1] = t;
				end
			end
		end
		expY.delete();
		expL.delete();
		expR.delete();
		for (int yy = y[0]; yy < y[2]; yy++) begin
			lx = edgeX(x[0], y[0], x[2], y[2], yy);
			if (yy < y[1])
				sx = edgeX(x[0], y[0], x[1], y[1], yy);
			else
				sx = edgeX(x[1], y[1], x[2], y[2], yy);
			expY.push_back(yy);
			expL.push_back(lx < sx ? lx : sx);
			expR.push_back(lx < sx ? sx : lx);
		end
	endtask

	task automatic compareField(input string what, input int got, input int want);
		if (got != want) begin
			$display("ERROR %0t ns: %s is %0d, expected %0d", $time, what, got, want);
			valueErrs++;
		end
	endtask

	always @(posedge clk) begin
		if (arstN) begin
			if (newTri) begin
				if (active) begin
					$display("New triangle accepted before the previous one finished");
					protoErrs++;
				end
				buildSpans(triX, triY);
				active = 1'b1;
				seen = 0;
				wantSpans = triSpans;
				wantKnown = spansKnown;
			end
			if (spanValid) begin
				seen++;
				if (expY.size() == 0) begin
					$display("Span at y %0d arrived with none pending at %0t ns", spanY, $time);
					protoErrs++;
				end else begin
					compareField("spanY", spanY, expY.pop_front());
					compareField("spanXl", spanXl, expL.pop_front());
					compareField("spanXr", spanXr, expR.pop_front());
				end
				if (spanXl > spanXr) begin
					$display("ERROR %0t ns: spanXl %0d above spanXr %0d", $time, spanXl, spanXr);
					valueErrs++;
				end
			end else if (prevValid && expY.size() != 0) begin
				$display("Spans stopped for a cycle at %0t ns with spans still pending", $time);
				protoErrs++;
			end
			prevValid = spanValid;
			if (done) begin
				if (!active) begin
					$display("done pulsed with no triangle running at %0t ns", $time);
					protoErrs++;
				end else begin
					compareField("missing spans", expY.size(), 0);
					if (wantKnown)
						compareField("span count", seen, wantSpans);
					active = 1'b0;
				end
			end
		end
	end

endmodule

// File: rasterTb.sv
module rasterTb import rastPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int period = 40;
	localparam int unsigned seed = 32'he681;
	localparam int randN = 40;
	localparam int maxFileTri = 32;
	localparam int cyclesPerTri = 3 * (divCycles + 1) + 4096 + 10;

	logic clk = 1'b0;
	logic arstN;
	logic start;
	logic [vertN-1:0][coordW-1:0] vertX;
	logic [vertN-1:0][coordW-1:0] vertY;
	logic busy;
	logic spanValid;
	logic [coordW-1:0] spanY;
	logic [coordW-1:0] spanXl;
	logic [coordW-1:0] spanXr;
	logic done;
	logic newTri;
	int triSpans;
	logic spansKnown;
	int valueErrs;
	int protoErrs;
	int triTotal = 0;
	logic [coordW-1:0] fileMem [0:1+7*maxFileTri-1];

	always #(period / 2) clk = ~clk;

	rasterTop dut0 (.*);

	rasterChecker chk0 (.clk, .arstN, .newTri, .triX(vertX), .triY(vertY), .triSpans,
		.spansKnown, .spanValid, .spanY, .spanXl, .spanXr, .done, .valueErrs, .protoErrs);

	task automatic runTriangle(input logic [vertN-1:0][coordW-1:0] tx,
		input logic [vertN-1:0][coordW-1:0] ty, input int spans, input bit known,
		input bit poke);
		start <= 1'b1;
		vertX <= tx;
		vertY <= ty;
		newTri <= 1'b1;
		triSpans <= spans;
		spansKnown <= known;
		@(posedge clk);
		start <= 1'b0;
		newTri <= 1'b0;
		if (poke) begin
			do @(posedge clk); while (busy !== 1'b1);
			// Second start mid-triangle with other vertices.
			start <= 1'b1;
			vertX <= ~tx;
			vertY <= ~ty;
			@(posedge clk);
			start <= 1'b0;
		end
		do @(posedge clk); while (done !== 1'b1);
	endtask

	initial begin
		int fileN;
		int base;
		int seedDummy;
		int assertErrs;
		logic [vertN-1:0][coordW-1:0] rx;
		logic [vertN-1:0][coordW-1:0] ry;
		arstN = 1'b0;
		start = 1'b0;
		vertX = '0;
		vertY = '0;
		newTri = 1'b0;
		triSpans = 0;
		spansKnown = 1'b0;
		seedDummy = $urandom(seed);
		$readmemh("triangleInput.txt", fileMem);
		fileN = fileMem[0];
		triTotal = fileN + randN + 1;
		repeat (2) @(posedge clk);
		arstN <= 1'b1;
		@(posedge clk);
		for (int n = 0; n < fileN; n++) begin
			base = 1 + 7 * n;
			for (int v = 0; v < vertN; v++) begin
				rx[v] = fileMem[base + 2 * v];
				ry[v] = fileMem[base + 2 * v + 1];
			end
			runTriangle(rx, ry, fileMem[base + 6], 1'b1, 1'b0);
		end
		// First file triangle again, with a start while busy.
		for (int v = 0; v < vertN; v++) begin
			rx[v] = fileMem[1 + 2 * v];
			ry[v] = fileMem[2 + 2 * v];
		end
		runTriangle(rx, ry, fileMem[7], 1'b1, 1'b1);
		for (int n = 0; n < randN; n++) begin
			for (int v = 0; v < vertN; v++) begin
				rx[v] = coordW'($urandom % 4096);
				ry[v] = coordW'($urandom % 1024);
			end
			runTriangle(rx, ry, 0, 1'b0, 1'b0);
		end
		repeat (2) @(posedge clk);
		assertErrs = dut0.asrt0.failCount;
		$display("Errors: value %0d, protocol %0d, assertion %0d", valueErrs, protoErrs,
			assertErrs);
		if (valueErrs + protoErrs + assertErrs == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		wait (triTotal != 0);
		#((triTotal * cyclesPerTri + 10) * period);
		$display("Watchdog expired: the DUT did not finish all triangles in time");
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: rasterTop.sv
module rasterTop import rastPkg::*; (
	input  logic clk,
	input  logic arstN,
	input  logic start,
	input  logic [vertN-1:0][coordW-1:0] vertX,
	input  logic [vertN-1:0][coordW-1:0] vertY,
	output logic busy,
	output logic spanValid,
	output logic [coordW-1:0] spanY,
	output logic [coordW-1:0] spanXl,
	output logic [coordW-1:0] spanXr,
	output logic done
);

	logic [vertN-1:0][coordW-1:0] sortX;
	logic [vertN-1:0][coordW-1:0] sortY;
	logic [vertN-1:0][coordW-1:0] aX;
	logic [vertN-1:0][coordW-1:0] aY;
	logic [vertN-1:0][coordW-1:0] bX;
	logic [vertN-1:0][coordW-1:0] bY;
	logic divStart;
	logic divDone;
	logic signed [deltaW-1:0] divDx;
	logic [coordW-1:0] divDy;
	logic signed [deltaW-1:0] divQuot;
	logic [coordW-1:0] divRem;
	logic load0;
	logic load1;
	logic load2;
	logic step0;
	logic step1;
	logic step2;
	logic [coordW-1:0] startX;
	logic signed [deltaW-1:0] quot;
	logic [coordW-1:0] rem;
	logic [coordW-1:0] dy;
	logic [coordW-1:0] curX0;
	logic [coordW-1:0] curX1;
	logic [coordW-1:0] curX2;

	spanControl ctrl0 (.*);

	edgeSorter sort0 (.vertX(sortX), .vertY(sortY), .aX, .aY, .bX, .bY);

	edgeDivider div0 (.*);

	// Long, upper and lower edge.
	edgeWalker walk0 (.clk, .arstN, .load(load0), .step(step0), .startX, .quot, .rem,
		.dy, .curX(curX0));
	edgeWalker walk1 (.clk, .arstN, .load(load1), .step(step1), .startX, .quot, .rem,
		.dy, .curX(curX1));
	edgeWalker walk2 (.clk, .arstN, .load(load2), .step(step2), .startX, .quot, .rem,
		.dy, .curX(curX2));

endmodule

// File: rasterTop_assertions.sv
module rasterTop_assertions (
	input logic clk,
	input logic arstN,
	input logic start,
	input logic busy,
	input logic spanValid,
	input logic done
);

	timeunit 1ns;
	timeprecision 100ps;

	int failCount = 0;

	spanInBusy: assert property (@(posedge clk) disable iff (!arstN) spanValid |-> busy)
		else begin
			$error("spanValid seen while busy is low");
			failCount++;
		end

	// Done is a single-cycle pulse.
	donePulse: assert property (@(posedge clk) disable iff (!arstN) done |=> !done)
		else begin
			$error("done held high for more than one cycle");
			failCount++;
		end

	doneNoSpan: assert property (@(posedge clk) disable iff (!arstN) !(done && spanValid))
		else begin
			$error("done and spanValid high in the same cycle");
			failCount++;
		end

	// Busy stays low out of reset until a start arrives.
	busyHold: assert property (@(posedge clk) disable iff (!arstN)
		!busy && !start |=> !busy)
		else begin
			$error("busy rose without a start");
			failCount++;
		end

	// Busy falls with the done pulse.
	doneBusy: assert property (@(posedge clk) disable iff (!arstN) done |-> !busy)
		else begin
			$error("busy still high while done pulses");
			failCount++;
		end

endmodule

bind rasterTop rasterTop_assertions asrt0 (
	.clk(clk),
	.arstN(arstN),
	.start(start),
	.busy(busy),
	.spanValid(spanValid),
	.done(done)
);

// File: spanControl.sv
module spanControl import rastPkg::*; (
	input  logic clk,
	input  logic arstN,
	input  logic start,
	input  logic [vertN-1:0][coordW-1:0] vertX,
	input  logic [vertN-1:0][coordW-1:0] vertY,
	input  logic [vertN-1:0][coordW-1:0] aX,
	input  logic [vertN-1:0][coordW-1:0] aY,
	input  logic [vertN-1:0][coordW-1:0] bX,
	input  logic [vertN-1:0][coordW-1:0] bY,
	input  logic divDone,
	input  logic signed [deltaW-1:0] divQuot,
	input  logic [coordW-1:0] divRem,
	input  logic [coordW-1:0] curX0,
	input  logic [coordW-1:0] curX1,
	input  logic [coordW-1:0] curX2,
	output logic [vertN-1:0][coordW-1:0] sortX,
	output logic [vertN-1:0][coordW-1:0] sortY,
	output logic divStart,
	output logic signed [deltaW-1:0] divDx,
	output logic [coordW-1:0] divDy,
	output logic load0,
	output logic load1,
	output logic load2,
	output logic step0,
	output logic step1,
	output logic step2,
	output logic [coordW-1:0] startX,
	output logic signed [deltaW-1:0] quot,
	output logic [coordW-1:0] rem,
	output logic [coordW-1:0] dy,
	output logic busy,
	output logic spanValid,
	output logic [coordW-1:0] spanY,
	output logic [coordW-1:0] spanXl,
	output logic [coordW-1:0] spanXr,
	output logic done
);

	logic [stW-1:0] state;
	logic [1:0] edgeSel;
	logic [1:0] nextSel;
	logic [1:0] divSel;
	logic nextValid;
	logic loadHit;
	logic [coordW-1:0] yCur;
	logic [vertN-1:0][coordW-1:0] edgeDy;
	logic [vertN-1:0][deltaW-1:0] edgeDx;
	logic upper;
	logic lastY;
	logic [coordW-1:0] activeX;

	always_comb begin
		for (int e = 0; e < vertN; e++) begin
			edgeDy[e] = bY[e] - aY[e];
			edgeDx[e] = {1'b0, bX[e]} - {1'b0, aX[e]};
		end
	end

	// Next edge that needs a division, flat edges skipped.
	always_comb begin
		nextValid = 1'b0;
		nextSel = 2'd0;
		if (edgeSel == 2'd0 && edgeDy[1] != '0) begin
			nextValid = 1'b1;
			nextSel = 2'd1;
		end else if (edgeSel != 2'd2 && edgeDy[2] != '0) begin
			nextValid = 1'b1;
			nextSel = 2'd2;
		end
	end

	assign loadHit = state == stDiv && divDone;
	assign divStart = (state == stSetup && edgeDy[0] != '0) || (loadHit && nextValid);
	assign divSel = state == stSetup ? 2'd0 : nextSel;
	assign divDx = edgeDx[divSel];
	assign divDy = edgeDy[divSel];

	// Finished edge goes to its walker.
	assign load0 = loadHit && edgeSel == 2'd0;
	assign load1 = loadHit && edgeSel == 2'd1;
	assign load2 = loadHit && edgeSel == 2'd2;
	assign startX = aX[edgeSel];
	assign quot = divQuot;
	assign rem = divRem;
	assign dy = edgeDy[edgeSel];

	// Upper short edge serves y below the middle vertex.
	assign upper = yCur < bY[1];
	assign lastY = yCur + 1'b1 == bY[0];
	assign activeX = upper ? curX1 : curX2;
	assign step0 = state == stWalk;
	assign step1 = step0 && upper;
	assign step2 = step0 && !upper;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= stIdle;
			edgeSel <= 2'd0;
			yCur <= '0;
			busy <= 1'b0;
			spanValid <= 1'b0;
			done <= 1'b0;
		end else begin
			spanValid <= 1'b0;
			done <= 1'b0;
			case (state)
				stIdle: begin
					if (start) begin
						busy <= 1'b1;
						state <= stSetup;
					end
				end
				stSetup: begin
					edgeSel <= 2'd0;
					yCur <= aY[0];
					// Zero height, no spans.
					state <= edgeDy[0] == '0 ? stFinish : stDiv;
				end
				stDiv: begin
					if (divDone) begin
						if (nextValid)
							edgeSel <= nextSel;
						else
							state <= stWalk;
					end
				end
				stWalk: begin
					spanValid <= 1'b1;
					yCur <= yCur + 1'b1;
					if (lastY)
						state <= stFinish;
				end
				stFinish: begin
					done <= 1'b1;
					busy <= 1'b0;
					state <= stIdle;
				end
				default: state <= stIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == stIdle && start) begin
			sortX <= vertX;
			sortY <= vertY;
		end
		if (state == stWalk) begin
			spanY <= yCur;
			spanXl <= curX0 <= activeX ? curX0 : activeX;
			spanXr <= curX0 <= activeX ? activeX : curX0;
		end
	end

endmodule

// File: triangleInput.txt
// First word is the number of triangles, then one triangle per line.
// Columns, all hex: x0 y0 x1 y1 x2 y2 expectedSpanCount
014
// Same triangle in all six vertex orders.
064 00a 12c 032 014 05a 050
064 00a 014 05a 12c 032 050
12c 032 064 00a 014 05a 050
12c 032 014 05a 064 00a 050
014 05a 064 00a 12c 032 050
014 05a 12c 032 064 00a 050
// Flat top, flat bottom.
00a 014 0c8 014 064 03c 028
096 005 01e 02d 104 02d 028
// Degenerate, no spans.
005 064 03c 064 12c 064 000
007 007 007 007 007 007 000
// Shallow negative slope.
fa0 00a 00a 01e 7d0 03c 032
// Steep edges.
032 000 035 12c 028 096 12c
// Full coordinate range.
000 000 fff fff 000 fff fff
// Single scanline.
00a 0c8 014 0c9 01e 0c8 001
// Vertical long edge.
12c 190 12c 1c2 0fa 1ae 032
// Exact negative division.
064 000 000 064 0c8 064 064
0c8 046 064 01e 12c 01e 028
fff 3e8 000 3eb 800 3f2 00a
00a 00a fa0 00b 014 fa0 f96
4d2 237 37a 4d2 c8a 929 6f2

// File: vlog.f
rastPkg.sv
edgeSorter.sv
edgeDivider.sv
edgeWalker.sv
spanControl.sv
rasterTop.sv
rasterTop_assertions.sv
rasterChecker.sv
rasterTb.sv
